// ==== src/map_switch_pkg.sv ====
`default_nettype none

package map_switch_pkg;

    // word widths
    localparam int KEY_W      = 10;
    localparam int ADDR_W     = 17;
    localparam int SCAN_W     = 10;
    localparam int LEVEL_W    = 3;
    localparam int JUMP_CNT_W = 30;

    localparam logic [LEVEL_W-1:0] LEVEL_MIN = 3'd1;
    localparam logic [LEVEL_W-1:0] LEVEL_MAX = 3'd5;

    // menu sprite geometry, half-scale coordinates
    localparam logic [ADDR_W-1:0] SPRITE_STRIDE = 17'd320;
    localparam logic [4:0][SCAN_W-1:0] ROW_TOP = {10'd200, 10'd160, 10'd120, 10'd80, 10'd40};
    localparam logic [SCAN_W-1:0] ROW_H        = 10'd25;
    localparam logic [SCAN_W-1:0] ICON_X0      = 10'd150;
    localparam logic [SCAN_W-1:0] HILITE_X0    = 10'd148;
    localparam logic [SCAN_W-1:0] ICON_X1      = 10'd170;
    localparam logic [SCAN_W-1:0] HILITE_SRC_X = 10'd127;

    // jump timing in clock cycles
    localparam int unsigned RISE_LIMIT_DEF = 70_000_000;
    localparam int unsigned FALL_LIMIT_DEF = 240_000_000;

    // key word as seen by the level menu
    typedef struct packed {
        logic rsvd9;
        logic confirm;
        logic rsvd7;
        logic prev_b;
        logic rsvd5;
        logic next_b;
        logic rsvd3;
        logic prev_a;
        logic rsvd1;
        logic next_a;
    } key_nav_t;

    // same word as seen during play
    typedef struct packed {
        logic [1:0] rsvd_hi;
        logic       right;
        logic       rsvd6;
        logic       left;
        logic       jump;
        logic [3:0] rsvd_lo;
    } key_move_t;

    typedef union packed {
        key_nav_t  nav;
        key_move_t move;
    } key_word_u;

    typedef struct packed {
        logic none_held;
        logic next;
        logic prev;
        logic confirm;
    } nav_cmd_t;

    typedef struct packed {
        logic jump;
        logic left;
        logic right;
    } move_cmd_t;

    typedef enum logic [3:0] {
        POSE_STATIC = 4'd6,
        POSE_RIGHT  = 4'd7,
        POSE_LEFT   = 4'd8,
        POSE_UP     = 4'd9
    } pose_t;

    typedef enum logic [1:0] {
        PHASE_IDLE = 2'd0,
        PHASE_RISE = 2'd1,
        PHASE_FALL = 2'd2
    } jump_phase_t;

    typedef struct packed {
        logic [SCAN_W-1:0] h;
        logic [SCAN_W-1:0] v;
    } scan_pos_t;

endpackage

`default_nettype wire

// ==== src/key_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module key_decode
    import map_switch_pkg::*;
(
    input  key_word_u key_down,
    output nav_cmd_t  nav,
    output move_cmd_t move
);

    logic next_held;
    logic prev_held;

    // either key of a pair counts
    assign next_held = key_down.nav.next_a | key_down.nav.next_b;
    assign prev_held = key_down.nav.prev_a | key_down.nav.prev_b;

    // menu view, one command at a time in priority order
    always_comb begin
        nav.none_held = (key_down == '0);
        nav.next      = next_held;
        nav.prev      = !next_held && prev_held;
        nav.confirm   = !next_held && !prev_held && key_down.nav.confirm;
    end

    // play view, raw held keys
    always_comb begin
        move.jump  = key_down.move.jump;
        move.left  = key_down.move.left;
        move.right = key_down.move.right;
    end

endmodule

`default_nettype wire

// ==== src/level_select.sv ====
`timescale 1ns/1ns
`default_nettype none

module level_select
    import map_switch_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  nav_cmd_t           nav,
    output logic [LEVEL_W-1:0] level,
    output logic               in_game
);

    // a key acts once, then waits for all keys up
    logic key_armed;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            level     <= LEVEL_MIN;
            in_game   <= 1'b0;
            key_armed <= 1'b1;
        end else if (!in_game) begin
            if (nav.none_held) begin
                key_armed <= 1'b1;
            end else if (key_armed) begin
                if (nav.next) begin
                    if (level < LEVEL_MAX) begin
                        level <= level + 1'b1;
                    end
                    key_armed <= 1'b0;
                end else if (nav.prev) begin
                    if (level > LEVEL_MIN) begin
                        level <= level - 1'b1;
                    end
                    key_armed <= 1'b0;
                end else if (nav.confirm) begin
                    // level freezes from here on
                    in_game <= 1'b1;
                end
            end
        end
    end

    level_in_range: assert property (
        @(posedge clk) disable iff (rst)
        (level >= LEVEL_MIN) && (level <= LEVEL_MAX)
    );

    // play is left only through reset
    in_game_sticky: assert property (
        @(posedge clk) disable iff (rst)
        in_game |=> in_game
    );

endmodule

`default_nettype wire

// ==== src/player_motion.sv ====
`timescale 1ns/1ns
`default_nettype none

module player_motion
    import map_switch_pkg::*;
#(
    parameter int unsigned RISE_LIMIT = RISE_LIMIT_DEF,
    parameter int unsigned FALL_LIMIT = FALL_LIMIT_DEF
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        in_game,
    input  move_cmd_t   move,
    input  logic        p1_collision,
    input  logic        p1_land,
    input  logic        should_down,
    output pose_t       pose,
    output jump_phase_t jump_phase
);

    localparam logic [JUMP_CNT_W-1:0] RISE_CNT = JUMP_CNT_W'(RISE_LIMIT);
    localparam logic [JUMP_CNT_W-1:0] FALL_CNT = JUMP_CNT_W'(FALL_LIMIT);

    logic [JUMP_CNT_W-1:0] jump_cnt;

    // fall half of the step
    jump_phase_t           fall_phase;
    logic [JUMP_CNT_W-1:0] fall_cnt;
    // full step, rise first
    jump_phase_t           step_phase;
    logic [JUMP_CNT_W-1:0] step_cnt;

    pose_t                 pose_next;
    jump_phase_t           phase_next;
    logic [JUMP_CNT_W-1:0] cnt_next;

    logic airborne;
    logic left_only;
    logic right_only;
    logic no_keys;
    logic jump_only;

    assign airborne   = (jump_phase != PHASE_IDLE);
    assign left_only  = move.left && !move.right;
    assign right_only = move.right && !move.left;
    assign no_keys    = !move.jump && !move.left && !move.right;
    assign jump_only  = move.jump && !move.left && !move.right;

    always_comb begin
        if (jump_cnt < FALL_CNT && !p1_land) begin
            fall_phase = PHASE_FALL;
            fall_cnt   = jump_cnt + 1'b1;
        end else begin
            // landed or timed out
            fall_phase = PHASE_IDLE;
            fall_cnt   = '0;
        end

        if (jump_phase != PHASE_FALL && jump_cnt < RISE_CNT && !p1_collision) begin
            step_phase = PHASE_RISE;
            step_cnt   = jump_cnt + 1'b1;
        end else begin
            step_phase = fall_phase;
            step_cnt   = fall_cnt;
        end
    end

    always_comb begin
        pose_next  = pose;
        phase_next = jump_phase;
        cnt_next   = jump_cnt;

        if (no_keys) begin
            pose_next = POSE_STATIC;
            if (!airborne) begin
                cnt_next = '0;
            end else begin
                phase_next = step_phase;
                cnt_next   = step_cnt;
            end
        end else if (jump_only) begin
            pose_next  = POSE_UP;
            phase_next = step_phase;
            cnt_next   = step_cnt;
        end else if (left_only || right_only) begin
            pose_next = left_only ? POSE_LEFT : POSE_RIGHT;
            if ((move.jump || airborne) && !should_down) begin
                phase_next = step_phase;
                cnt_next   = step_cnt;
            end else if (should_down) begin
                // walked off a ledge
                phase_next = fall_phase;
                cnt_next   = fall_cnt;
            end else begin
                phase_next = PHASE_IDLE;
            end
        end else if (airborne) begin
            // both sideways keys, pose holds
            phase_next = step_phase;
            cnt_next   = step_cnt;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pose       <= POSE_STATIC;
            jump_phase <= PHASE_IDLE;
            jump_cnt   <= '0;
        end else if (in_game) begin
            pose       <= pose_next;
            jump_phase <= phase_next;
            jump_cnt   <= cnt_next;
        end
    end

    no_fall_to_rise: assert property (
        @(posedge clk) disable iff (rst)
        (jump_phase == PHASE_FALL) |=> (jump_phase != PHASE_RISE)
    );

endmodule

`default_nettype wire

// ==== src/menu_pixel_addr.sv ====
`timescale 1ns/1ns
`default_nettype none

module menu_pixel_addr
    import map_switch_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  scan_pos_t          scan,
    input  logic [LEVEL_W-1:0] level,
    input  logic               in_game,
    output logic [ADDR_W-1:0]  pixel_addr
);

    // menu art is drawn at half resolution
    logic [SCAN_W-1:0] h;
    logic [SCAN_W-1:0] v;
    logic [ADDR_W-1:0] addr_next;

    assign h = scan.h >> 1;
    assign v = scan.v >> 1;

    always_comb begin
        logic              hilite;
        logic [SCAN_W-1:0] x0;
        logic [SCAN_W-1:0] src_x;
        logic [SCAN_W-1:0] row_y;

        addr_next = '0;
        for (int k = 0; k < 5; k++) begin
            hilite = (level == LEVEL_W'(k + 1));
            // highlighted icon is wider and cut from another sheet column
            x0    = hilite ? HILITE_X0 : ICON_X0;
            src_x = hilite ? HILITE_SRC_X : ICON_X0;
            row_y = v - ROW_TOP[k] + 1'b1;
            if (!in_game && v >= ROW_TOP[k] && v < ROW_TOP[k] + ROW_H
                    && h >= x0 && h < ICON_X1) begin
                addr_next = ADDR_W'(h - src_x) + ADDR_W'(row_y) * SPRITE_STRIDE;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pixel_addr <= '0;
        end else begin
            pixel_addr <= addr_next;
        end
    end

endmodule

`default_nettype wire

// ==== src/map_switch.sv ====
`timescale 1ns/1ns
`default_nettype none

module map_switch
    import map_switch_pkg::*;
#(
    parameter int unsigned RISE_LIMIT = RISE_LIMIT_DEF,
    parameter int unsigned FALL_LIMIT = FALL_LIMIT_DEF
) (
    input  logic               clk,
    input  logic               rst,
    input  key_word_u          key_down,
    input  scan_pos_t          scan,
    input  logic               p1_collision,
    input  logic               p1_land,
    input  logic               should_down,
    output logic [LEVEL_W-1:0] level,
    output logic               in_game,
    output pose_t              pose,
    output jump_phase_t        jump_phase,
    output logic [ADDR_W-1:0]  pixel_addr
);

    nav_cmd_t  nav;
    move_cmd_t move;

    // decode
    key_decode key_decode_i (
        .key_down (key_down),
        .nav      (nav),
        .move     (move)
    );

    // execute
    level_select level_select_i (
        .clk     (clk),
        .rst     (rst),
        .nav     (nav),
        .level   (level),
        .in_game (in_game)
    );

    player_motion #(
        .RISE_LIMIT (RISE_LIMIT),
        .FALL_LIMIT (FALL_LIMIT)
    ) player_motion_i (
        .clk          (clk),
        .rst          (rst),
        .in_game      (in_game),
        .move         (move),
        .p1_collision (p1_collision),
        .p1_land      (p1_land),
        .should_down  (should_down),
        .pose         (pose),
        .jump_phase   (jump_phase)
    );

    // result
    menu_pixel_addr menu_pixel_addr_i (
        .clk        (clk),
        .rst        (rst),
        .scan       (scan),
        .level      (level),
        .in_game    (in_game),
        .pixel_addr (pixel_addr)
    );

endmodule

`default_nettype wire

// ==== dv/map_switch_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module map_switch_tb
    import map_switch_pkg::*;
();

    localparam int RISE_TB = 8;
    localparam int FALL_TB = 20;

    logic               clk;
    logic               rst;
    key_word_u          key_down;
    scan_pos_t          scan;
    logic               p1_collision;
    logic               p1_land;
    logic               should_down;
    logic [LEVEL_W-1:0] level;
    logic               in_game;
    pose_t              pose;
    jump_phase_t        jump_phase;
    logic [ADDR_W-1:0]  pixel_addr;

    int   errors;
    int   checks;
    int   exp_level;
    logic exp_in_game;

    map_switch #(
        .RISE_LIMIT (RISE_TB),
        .FALL_LIMIT (FALL_TB)
    ) map_switch_i (
        .clk          (clk),
        .rst          (rst),
        .key_down     (key_down),
        .scan         (scan),
        .p1_collision (p1_collision),
        .p1_land      (p1_land),
        .should_down  (should_down),
        .level        (level),
        .in_game      (in_game),
        .pose         (pose),
        .jump_phase   (jump_phase),
        .pixel_addr   (pixel_addr)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // hang guard for the whole run
    initial begin
        #50000;
        $display("simulation did not finish within the time limit");
        $display("*** TEST FAILED ***");
        $finish;
    end

    // one clock, then the drive point 1 ns later
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic set_keys(input logic [KEY_W-1:0] word);
        key_down = word;
    endtask

    task automatic check_level(input string name, input logic [LEVEL_W-1:0] got,
                               input logic [LEVEL_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_pose(input string name, input pose_t got, input pose_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t %s got %s expected %s", $time, name, got.name(), exp.name());
        end
    endtask

    task automatic check_phase(input string name, input jump_phase_t got,
                               input jump_phase_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t %s got %s expected %s", $time, name, got.name(), exp.name());
        end
    endtask

    task automatic check_addr(input string name, input logic [ADDR_W-1:0] got,
                              input logic [ADDR_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("ERROR %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // ticks until the phase leaves ph, bounded by limit
    task automatic wait_phase_leave(input jump_phase_t ph, input int limit, output int cycles);
        cycles = 0;
        while (jump_phase == ph && cycles < limit) begin
            tick();
            cycles++;
        end
        if (jump_phase == ph) begin
            errors++;
            $display("jump phase still %s after %0d cycles, wait timed out", ph.name(), limit);
        end
    endtask

    // menu row rule at half scale, rows at 40 * (k + 1)
    function automatic logic [ADDR_W-1:0] expected_addr(input int h_full, input int v_full,
                                                        input int lvl, input logic playing);
        int h;
        int v;
        int top;
        int x0;
        int src;
        int result;
        h = h_full / 2;
        v = v_full / 2;
        result = 0;
        for (int k = 0; k < 5; k++) begin
            top = 40 * (k + 1);
            x0  = (lvl == k + 1) ? 148 : 150;
            src = (lvl == k + 1) ? 127 : 150;
            if (!playing && v >= top && v < top + 25 && h >= x0 && h < 170) begin
                result = (h - src) + (v - top + 1) * 320;
            end
        end
        return result[ADDR_W-1:0];
    endfunction

    task automatic scan_and_check(input int h_full, input int v_full);
        scan.h = h_full[SCAN_W-1:0];
        scan.v = v_full[SCAN_W-1:0];
        tick();
        check_addr("pixel_addr", pixel_addr,
                   expected_addr(h_full, v_full, exp_level, exp_in_game));
    endtask

    // hold a nav key, then release so the lockout re-arms
    task automatic nav_press(input logic [KEY_W-1:0] word, input int dir, input int hold);
        set_keys(word);
        tick();
        if (dir > 0 && exp_level < 5) begin
            exp_level++;
        end else if (dir < 0 && exp_level > 1) begin
            exp_level--;
        end
        check_level("level", level, exp_level[LEVEL_W-1:0]);
        repeat (hold - 1) tick();
        check_level("level", level, exp_level[LEVEL_W-1:0]);
        set_keys('0);
        tick();
    endtask

    task automatic test_reset();
        check_level("level", level, LEVEL_MIN);
        check_flag("in_game", in_game, 1'b0);
        check_pose("pose", pose, POSE_STATIC);
        check_phase("jump_phase", jump_phase, PHASE_IDLE);
        check_addr("pixel_addr", pixel_addr, '0);
    endtask

    task automatic test_navigation();
        // long hold counts once
        nav_press(10'h001, 1, 5);
        nav_press(10'h010, 1, 1);
        nav_press(10'h001, 1, 2);
        nav_press(10'h010, 1, 1);
        nav_press(10'h001, 1, 1);
        nav_press(10'h004, -1, 3);
        nav_press(10'h040, -1, 1);
        nav_press(10'h004, -1, 1);
        nav_press(10'h040, -1, 2);
        nav_press(10'h004, -1, 1);
    endtask

    task automatic test_menu_addr();
        int h_full;
        int v_full;
        for (int lvl = 1; lvl <= 5; lvl++) begin
            for (int i = 0; i < 30; i++) begin
                if (i % 2 == 0) begin
                    h_full = 290 + int'($urandom % 60);
                    v_full = 70 + int'($urandom % 360);
                end else begin
                    h_full = int'($urandom % 1024);
                    v_full = int'($urandom % 1024);
                end
                scan_and_check(h_full, v_full);
            end
            // extra highlight columns, same columns on another row, and above all rows
            scan_and_check(296, 2 * (40 * lvl + 3));
            scan_and_check(299, 2 * (40 * lvl + 24) + 1);
            scan_and_check(296, 2 * (40 * (lvl % 5 + 1) + 3));
            scan_and_check(320, 20);
            if (lvl < 5) begin
                nav_press(10'h001, 1, 1);
            end
        end
    endtask

    task automatic test_enter_play();
        set_keys(10'h100);
        tick();
        exp_in_game = 1'b1;
        check_flag("in_game", in_game, exp_in_game);
        set_keys('0);
        tick();
        set_keys(10'h001);
        tick();
        check_level("level", level, exp_level[LEVEL_W-1:0]);
        set_keys(10'h004);
        tick();
        check_level("level", level, exp_level[LEVEL_W-1:0]);
        set_keys('0);
        scan_and_check(320, 2 * (40 * exp_level + 5));
        scan_and_check(300, 170);
        check_flag("in_game", in_game, 1'b1);
    endtask

    task automatic test_jump();
        int cycles;
        set_keys(10'h010);
        tick();
        check_pose("pose", pose, POSE_UP);
        check_phase("jump_phase", jump_phase, PHASE_RISE);
        wait_phase_leave(PHASE_RISE, 50, cycles);
        check_count("rise cycles", cycles, RISE_TB);
        check_phase("jump_phase", jump_phase, PHASE_FALL);
        wait_phase_leave(PHASE_FALL, 50, cycles);
        check_count("fall cycles", cycles, FALL_TB - RISE_TB);
        check_phase("jump_phase", jump_phase, PHASE_IDLE);
        set_keys('0);
        tick();
        check_pose("pose", pose, POSE_STATIC);

        // collision cuts the rise short
        set_keys(10'h010);
        repeat (2) tick();
        check_phase("jump_phase", jump_phase, PHASE_RISE);
        p1_collision = 1'b1;
        tick();
        check_phase("jump_phase", jump_phase, PHASE_FALL);
        p1_collision = 1'b0;
        tick();
        check_phase("jump_phase", jump_phase, PHASE_FALL);
        p1_land = 1'b1;
        tick();
        check_phase("jump_phase", jump_phase, PHASE_IDLE);
        p1_land = 1'b0;
        set_keys('0);
        tick();
        check_phase("jump_phase", jump_phase, PHASE_IDLE);
    endtask

    task automatic test_sideways();
        set_keys(10'h020);
        tick();
        check_pose("pose", pose, POSE_LEFT);
        check_phase("jump_phase", jump_phase, PHASE_IDLE);
        set_keys(10'h080);
        tick();
        check_pose("pose", pose, POSE_RIGHT);
        // walking off a ledge
        set_keys(10'h020);
        should_down = 1'b1;
        tick();
        check_pose("pose", pose, POSE_LEFT);
        check_phase("jump_phase", jump_phase, PHASE_FALL);
        should_down = 1'b0;
        tick();
        check_phase("jump_phase", jump_phase, PHASE_FALL);
        p1_land = 1'b1;
        tick();
        check_phase("jump_phase", jump_phase, PHASE_IDLE);
        p1_land = 1'b0;
        set_keys('0);
        tick();
        check_pose("pose", pose, POSE_STATIC);
        check_phase("jump_phase", jump_phase, PHASE_IDLE);
    endtask

    initial begin
        errors       = 0;
        checks       = 0;
        exp_level    = 1;
        exp_in_game  = 1'b0;
        rst          = 1'b1;
        key_down     = '0;
        scan         = '0;
        p1_collision = 1'b0;
        p1_land      = 1'b0;
        should_down  = 1'b0;
        void'($urandom(32'h69e2));

        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        test_reset();
        test_navigation();
        test_menu_addr();
        test_enter_play();
        test_jump();
        test_sideways();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== map_switch.f ====
src/map_switch_pkg.sv
src/key_decode.sv
src/level_select.sv
src/player_motion.sv
src/menu_pixel_addr.sv
src/map_switch.sv
dv/map_switch_tb.sv

// ==== Makefile ====
TOOL    := verilator
TOP     := map_switch_tb
FLIST   := map_switch.f
OBJ_DIR := obj_dir
FLAGS   := --binary --timing --assert -j 0 --Mdir $(OBJ_DIR) --top-module $(TOP)
BIN     := $(OBJ_DIR)/V$(TOP)
LOG     := sim.log
SRCS    := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(TOOL) $(FLAGS) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q -F '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
